//--- Bender.yml
package:
  name: exec_unit

sources:
  # Packages first, then the interface and the modules.
  - rtl/rv_types_pkg.sv
  - rtl/exec_ctrl_pkg.sv
  - rtl/muldiv_if.sv
  - rtl/alu.sv
  - rtl/muldiv_unit.sv
  - rtl/execute_stage.sv
  - rtl/exec_unit_top.sv

  - target: test
    files:
      - dv/exec_unit_tb.sv

//--- dv/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;
    import rv_types_pkg::*;
    import exec_ctrl_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 4;
    localparam int    STEPS        = 1;
    // Stall length of a full multiply or divide.
    localparam int    MD_CYCLES    = XLEN / STEPS + 1;
    localparam int    N_ALU        = 200;
    localparam int    N_BRANCH     = 100;
    localparam int    N_MUL        = 40;
    localparam int    N_DIV        = 40;
    // Reset check, 16 edge multiplies, 8 divide corners, flush pair.
    localparam int    N_DIRECTED   = 27;
    localparam int    NUM_TESTS    = N_ALU + N_BRANCH + N_MUL + N_DIV + N_DIRECTED;
    localparam time   TIMEOUT      = (NUM_TESTS * (XLEN + 4) + RESET_CYCLES) * CLK_PERIOD;
    localparam uint_x INT_MIN      = {1'b1, {(XLEN-1){1'b0}}};
    localparam uint_x INT_MAX      = {1'b0, {(XLEN-1){1'b1}}};

    logic     clk;
    logic     i_rst_n;
    logic     i_flush;
    logic     i_valid;
    logic     i_is_new;
    addr_t    i_pc;
    alu_sel_t i_alu_sel;
    br_sel_t  i_br_sel;
    logic     i_jmp_pc;
    logic     i_jmp_reg;
    uint_x    i_imm_b;
    uint_x    i_imm_j;
    uint_x    i_op1;
    uint_x    i_op2;
    uint_x    o_alu_out;
    logic     o_branch_taken;
    addr_t    o_branch_target;
    logic     o_stall;

    // Expected outputs of the instruction in flight.
    uint_x    exp_result;
    logic     exp_taken;
    addr_t    exp_target;
    logic     exp_md;
    logic     pending      = 1'b0;
    int       stall_cycles = 0;
    int       errors       = 0;

    alu_sel_t mul_ops[4] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    alu_sel_t div_ops[4] = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    uint_x    edge_a[4]  = '{INT_MIN, INT_MAX, INT_MIN, '1};
    uint_x    edge_b[4]  = '{INT_MIN, INT_MAX, INT_MAX, INT_MIN};

    exec_unit_top #(.STEPS_PER_CYCLE(STEPS)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void predict(
        input  alu_sel_t sel, input br_sel_t br, input logic jpc, input logic jreg,
        input  addr_t pc, input uint_x imm_b, input uint_x imm_j, input uint_x a, input uint_x b,
        output uint_x res, output logic taken, output addr_t target
    );
        logic [2*XLEN-1:0]   prod_ss;
        logic [2*XLEN-1:0]   prod_su;
        logic [2*XLEN-1:0]   prod_uu;
        logic signed [XLEN-1:0] q_s;
        logic signed [XLEN-1:0] r_s;
        logic                overflow;
        logic                cond;
        addr_t               raw;

        prod_ss  = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
        prod_su  = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
        prod_uu  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        q_s      = $signed(a) / $signed(b);
        r_s      = $signed(a) % $signed(b);
        overflow = a == INT_MIN && b == '1;
        case (sel)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_AND:    res = a & b;
            ALU_OR:     res = a | b;
            ALU_XOR:    res = a ^ b;
            ALU_SLL:    res = a << b[4:0];
            ALU_SRL:    res = a >> b[4:0];
            ALU_SRA:    res = $signed(a) >>> b[4:0];
            ALU_SLT:    res = uint_x'($signed(a) < $signed(b));
            ALU_SLTU:   res = uint_x'(a < b);
            ALU_COPY2:  res = b;
            ALU_MUL:    res = prod_uu[XLEN-1:0];
            ALU_MULH:   res = prod_ss[2*XLEN-1:XLEN];
            ALU_MULHSU: res = prod_su[2*XLEN-1:XLEN];
            ALU_MULHU:  res = prod_uu[2*XLEN-1:XLEN];
            ALU_DIV:    res = (b == '0) ? '1 : overflow ? a : uint_x'(q_s);
            ALU_DIVU:   res = (b == '0) ? '1 : a / b;
            ALU_REM:    res = (b == '0) ? a : overflow ? '0 : uint_x'(r_s);
            default:    res = (b == '0) ? a : a % b;
        endcase
        case (br)
            BR_BEQ:  cond = a == b;
            BR_BNE:  cond = a != b;
            BR_BLT:  cond = $signed(a) < $signed(b);
            BR_BGE:  cond = $signed(a) >= $signed(b);
            BR_BLTU: cond = a < b;
            BR_BGEU: cond = a >= b;
            default: cond = 1'b0;
        endcase
        taken  = jpc || jreg || cond;
        raw    = jpc ? pc + imm_j : jreg ? a + b : pc + imm_b;
        target = {raw[XLEN-1:1], 1'b0};
    endfunction

    // Biased toward the values that break sign handling.
    function automatic uint_x rand_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return uint_x'(1);
            2:       return INT_MIN;
            3:       return INT_MAX;
            4:       return '1;
            default: return $urandom;
        endcase
    endfunction

    task automatic check_equal(input uint_x actual, input uint_x expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic run_instr(input alu_sel_t sel, input br_sel_t br, input logic jpc,
                             input logic jreg, input uint_x a, input uint_x b);
        addr_t pc;
        uint_x imm_b;
        uint_x imm_j;

        pc    = $urandom;
        imm_b = $urandom;
        imm_j = $urandom;
        @(posedge clk);
        i_valid   <= 1'b1;
        i_is_new  <= 1'b1;
        i_flush   <= 1'b0;
        i_pc      <= pc;
        i_alu_sel <= sel;
        i_br_sel  <= br;
        i_jmp_pc  <= jpc;
        i_jmp_reg <= jreg;
        i_imm_b   <= imm_b;
        i_imm_j   <= imm_j;
        i_op1     <= a;
        i_op2     <= b;
        predict(sel, br, jpc, jreg, pc, imm_b, imm_j, a, b, exp_result, exp_taken, exp_target);
        exp_md       = sel >= ALU_MUL;
        stall_cycles = 0;
        pending      = 1'b1;
        @(posedge clk);
        i_is_new <= 1'b0;
        while (pending) begin
            @(posedge clk);
        end
        // Same instruction still presented, result must hold.
        @(negedge clk);
        check_equal(o_alu_out, exp_result, "o_alu_out while held");
        check_equal(uint_x'(o_stall), '0, "o_stall while held");
    endtask

    // Outputs are compared once the stage stops stalling.
    always @(negedge clk) begin
        if (pending && o_stall) begin
            stall_cycles++;
        end
        if (pending && !exp_md) begin
            check_equal(uint_x'(o_stall), '0, "o_stall on a non-M operation");
        end
        if (pending && !o_stall) begin
            check_equal(o_alu_out, exp_result, "o_alu_out");
            check_equal(uint_x'(o_branch_taken), uint_x'(exp_taken), "o_branch_taken");
            check_equal(o_branch_target, exp_target, "o_branch_target");
            check_equal(uint_x'(o_branch_target[0]), '0, "o_branch_target bit 0");
            pending = 1'b0;
        end
    end

    initial begin
        void'($urandom(33));
        i_rst_n   = 1'b0;
        i_flush   = 1'b0;
        i_valid   = 1'b0;
        i_is_new  = 1'b0;
        i_pc      = '0;
        i_alu_sel = ALU_ADD;
        i_br_sel  = BR_NONE;
        i_jmp_pc  = 1'b0;
        i_jmp_reg = 1'b0;
        i_imm_b   = '0;
        i_imm_j   = '0;
        i_op1     = '0;
        i_op2     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;

        // Nothing is taken or stalled while i_valid is low.
        @(posedge clk);
        i_alu_sel <= ALU_DIV;
        i_is_new  <= 1'b1;
        i_jmp_pc  <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_equal(uint_x'(o_stall), '0, "o_stall with i_valid low");
            check_equal(uint_x'(o_branch_taken), '0, "o_branch_taken with i_valid low");
        end

        for (int i = 0; i < N_ALU; i++) begin
            run_instr(alu_sel_t'($urandom_range(0, int'(ALU_COPY2))), BR_NONE, 1'b0, 1'b0,
                      rand_operand(), rand_operand());
        end
        for (int i = 0; i < N_BRANCH; i++) begin
            run_instr(alu_sel_t'($urandom_range(0, int'(ALU_COPY2))),
                      br_sel_t'($urandom_range(0, int'(BR_BGEU))),
                      $urandom_range(0, 4) == 0, $urandom_range(0, 4) == 0,
                      rand_operand(), rand_operand());
        end
        for (int i = 0; i < N_MUL; i++) begin
            run_instr(mul_ops[i % 4], BR_NONE, 1'b0, 1'b0, rand_operand(), rand_operand());
        end
        for (int i = 0; i < 16; i++) begin
            run_instr(mul_ops[i / 4], BR_NONE, 1'b0, 1'b0, edge_a[i % 4], edge_b[i % 4]);
        end
        for (int i = 0; i < N_DIV; i++) begin
            run_instr(div_ops[i % 4], BR_NONE, 1'b0, 1'b0, rand_operand(), rand_operand());
        end
        for (int i = 0; i < 4; i++) begin
            run_instr(div_ops[i], BR_NONE, 1'b0, 1'b0, $urandom, '0);
            run_instr(div_ops[i], BR_NONE, 1'b0, 1'b0, INT_MIN, '1);
        end

        // Abandon a divide part way, then the unit must take a new multiply.
        @(posedge clk);
        i_alu_sel <= ALU_DIV;
        i_op1     <= uint_x'(32'h1234_5678);
        i_op2     <= uint_x'(32'h0000_0123);
        i_is_new  <= 1'b1;
        @(posedge clk);
        i_is_new <= 1'b0;
        repeat (10) @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        @(negedge clk);
        check_equal(uint_x'(o_stall), '0, "o_stall after flush");
        run_instr(ALU_MULHU, BR_NONE, 1'b0, 1'b0, uint_x'(32'hdead_beef), uint_x'(32'hcafe_f00d));
        // A unit left busy by the divide would stretch the stall.
        check_equal(uint_x'(stall_cycles), uint_x'(MD_CYCLES), "multiply stall after flush");

        repeat (2) @(posedge clk);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the DUT never finished the test sequence.");
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- exec_unit_top.f
rtl/rv_types_pkg.sv
rtl/exec_ctrl_pkg.sv
rtl/muldiv_if.sv
rtl/alu.sv
rtl/muldiv_unit.sv
rtl/execute_stage.sv
rtl/exec_unit_top.sv
dv/exec_unit_tb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_ctrl_pkg::alu_sel_t i_alu_sel,
    input  exec_ctrl_pkg::br_sel_t  i_br_sel,
    input  rv_types_pkg::uint_x     i_op1,
    input  rv_types_pkg::uint_x     i_op2,
    output rv_types_pkg::uint_x     o_result,
    output logic                    o_branch_take
);
    import rv_types_pkg::*;
    import exec_ctrl_pkg::*;

    shamt_t shamt;
    logic   lt_s;
    logic   lt_u;
    logic   eq;

    assign shamt = i_op2[$bits(shamt_t)-1:0];
    assign lt_s  = $signed(i_op1) < $signed(i_op2);
    assign lt_u  = i_op1 < i_op2;
    assign eq    = i_op1 == i_op2;

    always_comb begin
        case (i_alu_sel)
            ALU_ADD:   o_result = i_op1 + i_op2;
            ALU_SUB:   o_result = i_op1 - i_op2;
            ALU_AND:   o_result = i_op1 & i_op2;
            ALU_OR:    o_result = i_op1 | i_op2;
            ALU_XOR:   o_result = i_op1 ^ i_op2;
            ALU_SLL:   o_result = i_op1 << shamt;
            ALU_SRL:   o_result = i_op1 >> shamt;
            ALU_SRA:   o_result = $signed(i_op1) >>> shamt;
            ALU_SLT:   o_result = uint_x'(lt_s);
            ALU_SLTU:  o_result = uint_x'(lt_u);
            ALU_COPY2: o_result = i_op2;
            // M codes are served by the muldiv unit.
            default:   o_result = '0;
        endcase
    end

    always_comb begin
        case (i_br_sel)
            BR_BEQ:  o_branch_take = eq;
            BR_BNE:  o_branch_take = !eq;
            BR_BLT:  o_branch_take = lt_s;
            BR_BGE:  o_branch_take = !lt_s;
            BR_BLTU: o_branch_take = lt_u;
            BR_BGEU: o_branch_take = !lt_u;
            default: o_branch_take = 1'b0;
        endcase
    end

endmodule

//--- rtl/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

    // ALU operation select, RV32I codes first, then the M extension.
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_COPY2,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_sel_t;

    // Branch condition select.
    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_sel_t;

    // Operand signedness from decode.
    typedef enum logic {
        SIGN_UNSIGNED,
        SIGN_SIGNED
    } sign_sel_t;

    // True for the eight M extension operations.
    function automatic logic is_muldiv(alu_sel_t sel);
        return sel inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                           ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

endpackage

//--- rtl/exec_unit_top.sv
`timescale 1ns/1ps

module exec_unit_top #(
    parameter int STEPS_PER_CYCLE = 1
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_valid,
    input  logic                     i_is_new,
    input  rv_types_pkg::addr_t      i_pc,
    input  exec_ctrl_pkg::alu_sel_t  i_alu_sel,
    input  exec_ctrl_pkg::br_sel_t   i_br_sel,
    input  logic                     i_jmp_pc,
    input  logic                     i_jmp_reg,
    input  rv_types_pkg::uint_x      i_imm_b,
    input  rv_types_pkg::uint_x      i_imm_j,
    input  rv_types_pkg::uint_x      i_op1,
    input  rv_types_pkg::uint_x      i_op2,
    output rv_types_pkg::uint_x      o_alu_out,
    output logic                     o_branch_taken,
    output rv_types_pkg::addr_t      o_branch_target,
    output logic                     o_stall
);

    muldiv_if md_bus ();

    execute_stage u_exec (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_flush         (i_flush),
        .i_valid         (i_valid),
        .i_is_new        (i_is_new),
        .i_alu_sel       (i_alu_sel),
        .i_br_sel        (i_br_sel),
        .i_jmp_pc        (i_jmp_pc),
        .i_jmp_reg       (i_jmp_reg),
        .i_pc            (i_pc),
        .i_imm_b         (i_imm_b),
        .i_imm_j         (i_imm_j),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .md              (md_bus.requester),
        .o_alu_out       (o_alu_out),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_stall         (o_stall)
    );

    muldiv_unit #(
        .STEPS_PER_CYCLE (STEPS_PER_CYCLE)
    ) u_muldiv (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .mdif    (md_bus.unit)
    );

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_valid,
    input  logic                     i_is_new,
    input  exec_ctrl_pkg::alu_sel_t  i_alu_sel,
    input  exec_ctrl_pkg::br_sel_t   i_br_sel,
    input  logic                     i_jmp_pc,
    input  logic                     i_jmp_reg,
    input  rv_types_pkg::addr_t      i_pc,
    input  rv_types_pkg::uint_x      i_imm_b,
    input  rv_types_pkg::uint_x      i_imm_j,
    input  rv_types_pkg::uint_x      i_op1,
    input  rv_types_pkg::uint_x      i_op2,
    muldiv_if.requester              md,
    output rv_types_pkg::uint_x      o_alu_out,
    output logic                     o_branch_taken,
    output rv_types_pkg::addr_t      o_branch_target,
    output logic                     o_stall
);
    import rv_types_pkg::*;
    import exec_ctrl_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_CALC
    } state_t;

    state_t state;
    uint_x  alu_out;
    logic   alu_branch_take;
    uint_x  saved_result;
    logic   op_is_md;
    logic   md_done;
    addr_t  target_raw;

    alu u_alu (
        .i_alu_sel     (i_alu_sel),
        .i_br_sel      (i_br_sel),
        .i_op1         (i_op1),
        .i_op2         (i_op2),
        .o_result      (alu_out),
        .o_branch_take (alu_branch_take)
    );

    assign op_is_md = is_muldiv(i_alu_sel);
    assign md_done  = state == WAIT_CALC && md.resp_valid;

    // Request goes out in the same cycle the M op arrives.
    assign md.req_valid = i_valid
                          && ((i_is_new && state == IDLE && op_is_md) || state == WAIT_READY);
    assign md.req_sel   = i_alu_sel;
    assign md.req_op1   = i_op1;
    assign md.req_op2   = i_op2;
    assign md.kill      = i_flush || !i_valid;

    assign o_stall = i_valid
                     && ((i_is_new && state == IDLE && op_is_md)
                         || state == WAIT_READY
                         || (state == WAIT_CALC && !md.resp_valid));

    assign o_alu_out = md_done  ? md.resp_result :
                       op_is_md ? saved_result   : alu_out;

    assign o_branch_taken = i_valid && (i_jmp_pc || i_jmp_reg || alu_branch_take);

    always_comb begin
        if (i_jmp_pc) begin
            target_raw = i_pc + i_imm_j;
        end else if (i_jmp_reg) begin
            target_raw = i_op1 + i_op2;
        end else begin
            target_raw = i_pc + i_imm_b;
        end
    end

    assign o_branch_target = {target_raw[XLEN-1:1], 1'b0};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else if (i_flush || !i_valid) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_is_new && op_is_md) begin
                        state <= md.req_ready ? WAIT_CALC : WAIT_READY;
                    end
                end
                WAIT_READY: begin
                    if (md.req_ready) begin
                        state <= WAIT_CALC;
                    end
                end
                WAIT_CALC: begin
                    if (md.resp_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Held for as long as the finished instruction stays presented.
    always_ff @(posedge clk) begin
        if (md_done) begin
            saved_result <= md.resp_result;
        end
    end

endmodule

//--- rtl/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if;
    import rv_types_pkg::*;
    import exec_ctrl_pkg::*;

    // Request channel.
    logic     req_valid;
    logic     req_ready;
    alu_sel_t req_sel;
    uint_x    req_op1;
    uint_x    req_op2;

    // Single cycle response pulse.
    logic     resp_valid;
    uint_x    resp_result;

    // Abandons the running operation.
    logic     kill;

    modport requester (
        output req_valid, req_sel, req_op1, req_op2, kill,
        input  req_ready, resp_valid, resp_result
    );

    modport unit (
        input  req_valid, req_sel, req_op1, req_op2, kill,
        output req_ready, resp_valid, resp_result
    );

endinterface

//--- rtl/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int STEPS_PER_CYCLE = 1
) (
    input  logic  clk,
    input  logic  i_rst_n,
    muldiv_if.unit mdif
);
    import rv_types_pkg::*;
    import exec_ctrl_pkg::*;

    localparam int    RUN_CYCLES = XLEN / STEPS_PER_CYCLE;
    localparam int    CNT_W      = $clog2(RUN_CYCLES + 1);
    localparam uint_x INT_MIN    = {1'b1, {(XLEN-1){1'b0}}};

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   count;
    alu_sel_t           op_q;
    logic               neg_q;
    uint_x              hi_q;
    uint_x              lo_q;
    uint_x              b_q;

    logic               start;
    logic               sgn1;
    logic               sgn2;
    uint_x              mag1;
    uint_x              mag2;
    logic               div_zero;
    logic               div_ovf;
    logic               run_mul;
    uint_x              hi_n;
    uint_x              lo_n;
    logic [XLEN:0]      step_val;
    logic [2*XLEN-1:0]  prod_fix;
    uint_x              result;

    assign mdif.req_ready = state == IDLE;
    assign start = mdif.req_valid && mdif.req_ready && !mdif.kill
                   && is_muldiv(mdif.req_sel);

    // Operand signs; MULHSU treats only op1 as signed.
    assign sgn1 = mdif.req_op1[XLEN-1]
                  && (mdif.req_sel inside {ALU_MULH, ALU_MULHSU, ALU_DIV, ALU_REM});
    assign sgn2 = mdif.req_op2[XLEN-1]
                  && (mdif.req_sel inside {ALU_MULH, ALU_DIV, ALU_REM});
    assign mag1 = sgn1 ? -mdif.req_op1 : mdif.req_op1;
    assign mag2 = sgn2 ? -mdif.req_op2 : mdif.req_op2;

    assign div_zero = (mdif.req_sel inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU})
                      && mdif.req_op2 == '0;
    assign div_ovf  = (mdif.req_sel inside {ALU_DIV, ALU_REM})
                      && mdif.req_op1 == INT_MIN && mdif.req_op2 == '1;

    assign run_mul = op_q inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};

    // Shift-add multiply or restoring divide steps for one clock.
    always_comb begin
        hi_n     = hi_q;
        lo_n     = lo_q;
        step_val = '0;
        for (int i = 0; i < STEPS_PER_CYCLE; i++) begin
            if (run_mul) begin
                step_val     = {1'b0, hi_n} + (lo_n[0] ? {1'b0, b_q} : '0);
                {hi_n, lo_n} = {step_val, lo_n[XLEN-1:1]};
            end else begin
                step_val = {hi_n, lo_n[XLEN-1]} - {1'b0, b_q};
                if (!step_val[XLEN]) begin
                    hi_n = step_val[XLEN-1:0];
                    lo_n = {lo_n[XLEN-2:0], 1'b1};
                end else begin
                    hi_n = {hi_n[XLEN-2:0], lo_n[XLEN-1]};
                    lo_n = {lo_n[XLEN-2:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
            count <= '0;
        end else if (mdif.kill) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    count <= '0;
                    if (start) begin
                        state <= (div_zero || div_ovf) ? DONE : RUN;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(RUN_CYCLES - 1)) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Corner cases preload the final RISC-V result.
    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= mdif.req_sel;
            b_q  <= mag2;
            if (div_zero) begin
                hi_q  <= mdif.req_op1;
                lo_q  <= '1;
                neg_q <= 1'b0;
            end else if (div_ovf) begin
                hi_q  <= '0;
                lo_q  <= mdif.req_op1;
                neg_q <= 1'b0;
            end else begin
                hi_q  <= '0;
                lo_q  <= mag1;
                neg_q <= (mdif.req_sel inside {ALU_REM}) ? sgn1 : sgn1 ^ sgn2;
            end
        end else if (state == RUN) begin
            hi_q <= hi_n;
            lo_q <= lo_n;
        end
    end

    assign prod_fix = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};

    always_comb begin
        case (op_q)
            ALU_MUL:                          result = prod_fix[XLEN-1:0];
            ALU_MULH, ALU_MULHSU, ALU_MULHU:  result = prod_fix[2*XLEN-1:XLEN];
            ALU_DIV, ALU_DIVU:                result = neg_q ? -lo_q : lo_q;
            default:                          result = neg_q ? -hi_q : hi_q;
        endcase
    end

    assign mdif.resp_valid  = state == DONE && !mdif.kill;
    assign mdif.resp_result = result;

endmodule

//--- rtl/rv_types_pkg.sv
package rv_types_pkg;

    // Data path width of the integer core.
    localparam int XLEN = 32;

    // Operand and result word.
    typedef logic [XLEN-1:0] uint_x;

    // Instruction address.
    typedef logic [XLEN-1:0] addr_t;

    // Shift amount for the RV32I shift operations.
    typedef logic [4:0] shamt_t;

endpackage
